// File: rtl/sat_pkg.sv
// Sizes and encodings shared by the SAT engine
// A literal is {valid, negate, var}, and clause slot 0 sits in the low bits
// NUM_VARS must equal 2**VAR_W because bkt_unit walks a VAR_W+1 bit counter
package sat_pkg;

    localparam int NUM_VARS    = 8;
    localparam int VAR_W       = 3;
    localparam int NUM_CLAUSES = 16;
    localparam int CLS_W       = 4;
    localparam int NUM_LITS    = 3;

    localparam int LIT_W    = 5;
    localparam int LIT_VLD  = 4;              // Bit position of the valid flag
    localparam int LIT_NEG  = 3;              // Set for a negated literal
    localparam int CLAUSE_W = NUM_LITS * LIT_W;

    localparam int LVL_W = 4;                 // Level 0 is the root
    localparam int BIN_W = 10;

    // Analyze result when no decision is left to flip
    localparam logic [BIN_W-1:0] ROOT_BIN = '1;

    typedef enum logic [2:0] {
        IDLE          = 3'd0,
        BCP           = 3'd1,
        DECISION      = 3'd2,
        ANALYSIS      = 3'd3,
        BKT_CUR_BIN   = 3'd4,
        PARTIAL_SAT   = 3'd5,
        PARTIAL_UNSAT = 3'd6
    } core_state_t;

endpackage

// File: rtl/ctrl_core.sv
// DPLL sequencer for one bin; all command outputs are registered
// A start is only acted on in IDLE, but it always clears the previous result
module ctrl_core
    import sat_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             start_core_i,
    output logic             done_core_o,
    output logic             apply_imply_o,
    input  logic             done_imply_i,
    input  logic             conflict_i,
    output logic             start_decision_o,
    input  logic             done_decision_i,
    input  logic             all_c_is_sat_i,
    output logic             apply_analyze_o,
    input  logic             done_analyze_i,
    input  logic [BIN_W-1:0] bkt_bin_num_i,
    output logic             apply_bkt_cur_bin_o,
    input  logic             done_bkt_cur_bin_i,
    input  logic [BIN_W-1:0] cur_bin_num_i,
    output logic             sat_o,
    output logic             unsat_o
);

    core_state_t c_state;
    core_state_t n_state;
    logic        dec_issued;    // Start pulse already sent in this DECISION visit

    always_ff @(posedge clk)
    begin
        if (!rst)
            c_state <= IDLE;
        else
            c_state <= n_state;
    end

    always_comb
    begin
        n_state = c_state;
        case (c_state)
            IDLE:
                if (start_core_i)
                    n_state = BCP;
            BCP:
                if (done_imply_i)
                begin
                    if (conflict_i)
                        n_state = ANALYSIS;
                    else if (all_c_is_sat_i)
                        n_state = PARTIAL_SAT;
                    else
                        n_state = DECISION;
                end
            DECISION:
                if (done_decision_i)
                    n_state = all_c_is_sat_i ? PARTIAL_SAT : BCP;
            ANALYSIS:
                // A foreign bin number means the conflict went past the root
                if (done_analyze_i)
                    n_state = (bkt_bin_num_i == cur_bin_num_i) ? BKT_CUR_BIN : PARTIAL_UNSAT;
            BKT_CUR_BIN:
                if (done_bkt_cur_bin_i)
                    n_state = BCP;
            default:
                n_state = IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            apply_imply_o       <= 1'b0;
            start_decision_o    <= 1'b0;
            dec_issued          <= 1'b0;
            apply_analyze_o     <= 1'b0;
            apply_bkt_cur_bin_o <= 1'b0;
            done_core_o         <= 1'b0;
            sat_o               <= 1'b0;
            unsat_o             <= 1'b0;
        end
        else
        begin
            apply_imply_o       <= (c_state == BCP);
            dec_issued          <= (c_state == DECISION);
            start_decision_o    <= (c_state == DECISION) && !dec_issued;
            apply_analyze_o     <= (c_state == ANALYSIS);
            apply_bkt_cur_bin_o <= (c_state == BKT_CUR_BIN) && !done_bkt_cur_bin_i;

            if (c_state == PARTIAL_SAT || c_state == PARTIAL_UNSAT)
                done_core_o <= 1'b1;
            else if (start_core_i)
                done_core_o <= 1'b0;

            if (c_state == PARTIAL_SAT)
                sat_o <= 1'b1;
            else if (start_core_i)
                sat_o <= 1'b0;

            if (c_state == PARTIAL_UNSAT)
                unsat_o <= 1'b1;
            else if (start_core_i)
                unsat_o <= 1'b0;
        end
    end

endmodule

// File: rtl/var_table.sv
// Search trail, one record per variable, plus the current decision level
// Only one write port is active per cycle; clear_i wins over all of them
module var_table
    import sat_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           clear_i,
    input  logic                           imp_we_i,
    input  logic [VAR_W-1:0]               imp_var_i,
    input  logic                           imp_val_i,
    input  logic                           dec_we_i,
    input  logic [VAR_W-1:0]               dec_var_i,
    input  logic                           bkt_clr_i,
    input  logic [VAR_W-1:0]               bkt_clr_var_i,
    input  logic                           bkt_we_i,
    input  logic [VAR_W-1:0]               bkt_var_i,
    input  logic [LVL_W-1:0]               bkt_lvl_i,
    output logic [NUM_VARS-1:0]            value_o,
    output logic [NUM_VARS-1:0]            assigned_o,
    output logic [NUM_VARS-1:0][LVL_W-1:0] level_o,
    output logic [NUM_VARS-1:0]            decision_o,
    output logic [NUM_VARS-1:0]            flipped_o,
    output logic [LVL_W-1:0]               cur_lvl_o
);

    always_ff @(posedge clk)
    begin
        if (!rst || clear_i)
        begin
            value_o    <= '0;
            assigned_o <= '0;
            level_o    <= '0;
            decision_o <= '0;
            flipped_o  <= '0;
            cur_lvl_o  <= '0;
        end
        else if (imp_we_i)
        begin
            value_o[imp_var_i]    <= imp_val_i;
            assigned_o[imp_var_i] <= 1'b1;
            level_o[imp_var_i]    <= cur_lvl_o;
            decision_o[imp_var_i] <= 1'b0;
            flipped_o[imp_var_i]  <= 1'b0;
        end
        else if (dec_we_i)
        begin
            // Every decision tries 0 first
            cur_lvl_o             <= cur_lvl_o + 1'b1;
            value_o[dec_var_i]    <= 1'b0;
            assigned_o[dec_var_i] <= 1'b1;
            level_o[dec_var_i]    <= cur_lvl_o + 1'b1;
            decision_o[dec_var_i] <= 1'b1;
            flipped_o[dec_var_i]  <= 1'b0;
        end
        else if (bkt_clr_i)
        begin
            assigned_o[bkt_clr_var_i] <= 1'b0;
            decision_o[bkt_clr_var_i] <= 1'b0;
            flipped_o[bkt_clr_var_i]  <= 1'b0;
        end
        else if (bkt_we_i)
        begin
            cur_lvl_o             <= bkt_lvl_i;
            value_o[bkt_var_i]    <= ~value_o[bkt_var_i];   // Clearing left the value intact
            assigned_o[bkt_var_i] <= 1'b1;
            level_o[bkt_var_i]    <= bkt_lvl_i;
            decision_o[bkt_var_i] <= 1'b1;
            flipped_o[bkt_var_i]  <= 1'b1;
        end
    end

endmodule

// File: rtl/imply_unit.sv
// Clause memory and BCP sweeps, one clause per cycle while apply_i is high
// All-invalid clauses count as absent; loads must not overlap a sweep
module imply_unit
    import sat_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                load_we_i,
    input  logic [CLS_W-1:0]    load_addr_i,
    input  logic [CLAUSE_W-1:0] load_clause_i,
    input  logic                apply_i,
    input  logic [NUM_VARS-1:0] value_i,
    input  logic [NUM_VARS-1:0] assigned_i,
    output logic                we_o,
    output logic [VAR_W-1:0]    var_o,
    output logic                val_o,
    output logic                done_o,
    output logic                conflict_o,
    output logic                all_c_is_sat_o
);

    logic [CLAUSE_W-1:0] clause_mem [NUM_CLAUSES];
    logic [CLAUSE_W-1:0] clause;
    logic [CLS_W-1:0]    addr;
    logic                hold;      // Set by done until apply_i drops
    logic                changed;   // This sweep made an implication
    logic                sat_acc;
    logic                active;
    logic [VAR_W-1:0]    lit_var [NUM_LITS];
    logic [NUM_LITS-1:0] lit_vld, lit_true, lit_unas;
    logic [1:0]          n_unas;
    logic                cls_ok, cls_conflict, last;

    always_ff @(posedge clk)
    begin
        if (load_we_i)
            clause_mem[load_addr_i] <= load_clause_i;
    end

    assign clause = clause_mem[addr];

    always_comb
    begin
        var_o = '0;
        val_o = 1'b0;
        for (int i = 0; i < NUM_LITS; i++)
        begin
            lit_var[i]  = clause[i*LIT_W +: VAR_W];
            lit_vld[i]  = clause[i*LIT_W + LIT_VLD];
            lit_unas[i] = lit_vld[i] & ~assigned_i[lit_var[i]];
            lit_true[i] = lit_vld[i] & assigned_i[lit_var[i]]
                        & (value_i[lit_var[i]] ^ clause[i*LIT_W + LIT_NEG]);
            if (lit_unas[i])
            begin
                var_o = lit_var[i];
                val_o = ~clause[i*LIT_W + LIT_NEG];
            end
        end
        n_unas = lit_unas[0] + lit_unas[1] + lit_unas[2];
    end

    assign active       = apply_i & ~hold;
    assign cls_ok       = ~|lit_vld | |lit_true;
    assign cls_conflict = |lit_vld & ~|lit_true & ~|lit_unas;
    assign we_o         = active & ~cls_ok & (n_unas == 2'd1);
    assign last         = (addr == CLS_W'(NUM_CLAUSES - 1));

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            addr           <= '0;
            hold           <= 1'b0;
            changed        <= 1'b0;
            sat_acc        <= 1'b1;
            done_o         <= 1'b0;
            conflict_o     <= 1'b0;
            all_c_is_sat_o <= 1'b0;
        end
        else
        begin
            done_o <= 1'b0;
            if (!apply_i)
                hold <= 1'b0;
            if (active)
            begin
                if (cls_conflict || (last && !changed && !we_o))
                begin
                    done_o         <= 1'b1;
                    hold           <= 1'b1;
                    addr           <= '0;
                    changed        <= 1'b0;
                    sat_acc        <= 1'b1;
                    conflict_o     <= cls_conflict;
                    all_c_is_sat_o <= sat_acc & cls_ok;
                end
                else
                begin
                    addr    <= addr + 1'b1;   // Wraps into the next sweep
                    changed <= last ? 1'b0 : (changed | we_o);
                    sat_acc <= last ? 1'b1 : (sat_acc & cls_ok);
                end
            end
        end
    end

endmodule

// File: rtl/decide_unit.sv
// Picks the lowest unassigned variable and opens a new level with it
// With every variable assigned it still answers done, without a write
module decide_unit
    import sat_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                start_i,
    input  logic [NUM_VARS-1:0] assigned_i,
    output logic                we_o,
    output logic [VAR_W-1:0]    var_o,
    output logic                done_o
);

    // The lowest index is written last and wins the priority encoder
    always_comb
    begin
        var_o = '0;
        for (int i = NUM_VARS - 1; i >= 0; i--)
        begin
            if (!assigned_i[i])
                var_o = VAR_W'(i);
        end
    end

    assign we_o = start_i & ~&assigned_i;

    always_ff @(posedge clk)
    begin
        if (!rst)
            done_o <= 1'b0;
        else
            done_o <= start_i;
    end

endmodule

// File: rtl/analyze_unit.sv
// Chronological conflict analysis on the rising edge of apply_i
// Decisions sit on distinct levels, so the deepest unflipped one is unique
module analyze_unit
    import sat_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           apply_i,
    input  logic [NUM_VARS-1:0]            decision_i,
    input  logic [NUM_VARS-1:0]            flipped_i,
    input  logic [NUM_VARS-1:0][LVL_W-1:0] level_i,
    input  logic [BIN_W-1:0]               cur_bin_num_i,
    output logic [LVL_W-1:0]               bkt_lvl_o,
    output logic [VAR_W-1:0]               bkt_var_o,
    output logic [BIN_W-1:0]               bkt_bin_num_o,
    output logic                           done_o
);

    logic             apply_q;
    logic             found;
    logic [LVL_W-1:0] best_lvl;
    logic [VAR_W-1:0] best_var;

    always_comb
    begin
        found    = 1'b0;
        best_lvl = '0;
        best_var = '0;
        for (int i = 0; i < NUM_VARS; i++)
        begin
            if (decision_i[i] && !flipped_i[i] && (!found || level_i[i] > best_lvl))
            begin
                found    = 1'b1;
                best_lvl = level_i[i];
                best_var = VAR_W'(i);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            apply_q <= 1'b0;
            done_o  <= 1'b0;
        end
        else
        begin
            apply_q <= apply_i;
            done_o  <= apply_i & ~apply_q;
        end
    end

    always_ff @(posedge clk)
    begin
        if (apply_i && !apply_q)
        begin
            bkt_lvl_o     <= best_lvl;
            bkt_var_o     <= best_var;
            bkt_bin_num_o <= found ? cur_bin_num_i : ROOT_BIN;
        end
    end

endmodule

// File: rtl/bkt_unit.sv
// Clears every variable at or above the backtrack level, one per cycle
// then writes the flipped decision; bkt_lvl_i and bkt_var_i must stay stable
module bkt_unit
    import sat_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           apply_i,
    input  logic [LVL_W-1:0]               bkt_lvl_i,
    input  logic [VAR_W-1:0]               bkt_var_i,
    input  logic [NUM_VARS-1:0][LVL_W-1:0] level_i,
    output logic                           clr_o,
    output logic [VAR_W-1:0]               clr_var_o,
    output logic                           we_o,
    output logic [VAR_W-1:0]               var_o,
    output logic [LVL_W-1:0]               lvl_o,
    output logic                           done_o
);

    logic [VAR_W:0] cnt;     // Top bit marks the write cycle
    logic           hold;
    logic           active;

    assign active    = apply_i & ~hold;
    assign clr_var_o = cnt[VAR_W-1:0];
    assign clr_o     = active & ~cnt[VAR_W] & (level_i[clr_var_o] >= bkt_lvl_i);
    assign we_o      = active & cnt[VAR_W];
    assign var_o     = bkt_var_i;
    assign lvl_o     = bkt_lvl_i;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            cnt    <= '0;
            hold   <= 1'b0;
            done_o <= 1'b0;
        end
        else
        begin
            done_o <= 1'b0;
            if (!apply_i)
                hold <= 1'b0;
            if (active)
            begin
                if (cnt[VAR_W])
                begin
                    cnt    <= '0;
                    hold   <= 1'b1;
                    done_o <= 1'b1;
                end
                else
                    cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

// File: rtl/sat_engine_top.sv
// SAT engine for one bin; load only while idle, a clause write clears the trail
// cur_bin_num_i must never equal ROOT_BIN
module sat_engine_top
    import sat_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                load_we_i,
    input  logic [CLS_W-1:0]    load_addr_i,
    input  logic [CLAUSE_W-1:0] load_clause_i,
    input  logic [BIN_W-1:0]    cur_bin_num_i,
    input  logic                start_i,
    output logic                done_o,
    output logic                sat_o,
    output logic                unsat_o,
    output logic [NUM_VARS-1:0] model_o
);

    logic                           apply_imply, done_imply, conflict, all_c_is_sat;
    logic                           start_decision, done_decision;
    logic                           apply_analyze, done_analyze, apply_bkt, done_bkt;
    logic [BIN_W-1:0]               bkt_bin_num;
    logic [NUM_VARS-1:0]            assigned, decision, flipped;
    logic [NUM_VARS-1:0][LVL_W-1:0] level;
    logic                           imp_we, imp_val, dec_we, bkt_clr, bkt_we;
    logic [VAR_W-1:0]               imp_var, dec_var, bkt_clr_var, bkt_var, an_var;
    logic [LVL_W-1:0]               bkt_lvl, an_lvl;

    ctrl_core u_ctrl (
        .clk(clk), .rst(rst), .start_core_i(start_i), .done_core_o(done_o),
        .apply_imply_o(apply_imply), .done_imply_i(done_imply), .conflict_i(conflict),
        .start_decision_o(start_decision), .done_decision_i(done_decision),
        .all_c_is_sat_i(all_c_is_sat), .apply_analyze_o(apply_analyze),
        .done_analyze_i(done_analyze), .bkt_bin_num_i(bkt_bin_num),
        .apply_bkt_cur_bin_o(apply_bkt), .done_bkt_cur_bin_i(done_bkt),
        .cur_bin_num_i(cur_bin_num_i), .sat_o(sat_o), .unsat_o(unsat_o)
    );

    var_table u_vars (
        .clk(clk), .rst(rst), .clear_i(load_we_i),
        .imp_we_i(imp_we), .imp_var_i(imp_var), .imp_val_i(imp_val),
        .dec_we_i(dec_we), .dec_var_i(dec_var),
        .bkt_clr_i(bkt_clr), .bkt_clr_var_i(bkt_clr_var),
        .bkt_we_i(bkt_we), .bkt_var_i(bkt_var), .bkt_lvl_i(bkt_lvl),
        .value_o(model_o), .assigned_o(assigned), .level_o(level),
        .decision_o(decision), .flipped_o(flipped), .cur_lvl_o()
    );

    imply_unit u_imply (
        .clk(clk), .rst(rst), .load_we_i(load_we_i), .load_addr_i(load_addr_i),
        .load_clause_i(load_clause_i), .apply_i(apply_imply),
        .value_i(model_o), .assigned_i(assigned),
        .we_o(imp_we), .var_o(imp_var), .val_o(imp_val), .done_o(done_imply),
        .conflict_o(conflict), .all_c_is_sat_o(all_c_is_sat)
    );

    decide_unit u_decide (
        .clk(clk), .rst(rst), .start_i(start_decision), .assigned_i(assigned),
        .we_o(dec_we), .var_o(dec_var), .done_o(done_decision)
    );

    analyze_unit u_analyze (
        .clk(clk), .rst(rst), .apply_i(apply_analyze), .decision_i(decision),
        .flipped_i(flipped), .level_i(level), .cur_bin_num_i(cur_bin_num_i),
        .bkt_lvl_o(an_lvl), .bkt_var_o(an_var), .bkt_bin_num_o(bkt_bin_num),
        .done_o(done_analyze)
    );

    bkt_unit u_bkt (
        .clk(clk), .rst(rst), .apply_i(apply_bkt), .bkt_lvl_i(an_lvl),
        .bkt_var_i(an_var), .level_i(level), .clr_o(bkt_clr), .clr_var_o(bkt_clr_var),
        .we_o(bkt_we), .var_o(bkt_var), .lvl_o(bkt_lvl), .done_o(done_bkt)
    );

endmodule

// File: verif/ctrl_core_props.sv
// Checks on the result and decision outputs of ctrl_core
module ctrl_core_props (
    input logic clk,
    input logic rst,
    input logic start_decision_i,
    input logic done_core_i,
    input logic sat_i,
    input logic unsat_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_cnt = 0;

    no_dual_result: assert property (@(posedge clk) disable iff (!rst) !(sat_i && unsat_i))
    else
    begin
        fail_cnt++;
        $error("sat and unsat are high together");
    end

    // The decision start pulse never lasts a second cycle
    single_decision_pulse: assert property (@(posedge clk) disable iff (!rst)
        !(start_decision_i && $past(start_decision_i)))
    else
    begin
        fail_cnt++;
        $error("start_decision stayed high for two cycles");
    end

    done_has_result: assert property (@(posedge clk) disable iff (!rst)
        $rose(done_core_i) |-> (sat_i || unsat_i))
    else
    begin
        fail_cnt++;
        $error("done rose without a sat or unsat result");
    end

endmodule

bind ctrl_core ctrl_core_props u_props (
    .clk(clk), .rst(rst), .start_decision_i(start_decision_o),
    .done_core_i(done_core_o), .sat_i(sat_o), .unsat_i(unsat_o)
);

// File: verif/sat_engine_tb.sv
// Table-driven testbench for sat_engine_top that stops at the first error
// Random bins are judged by an exhaustive search over all 256 assignments
module sat_engine_tb
    import sat_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_DIRECTED = 4;
    localparam int NUM_CASES    = 10;
    localparam int TIMEOUT      = 5000;

    logic                clk;
    logic                rst;
    logic                load_we_i;
    logic [CLS_W-1:0]    load_addr_i;
    logic [CLAUSE_W-1:0] load_clause_i;
    logic [BIN_W-1:0]    cur_bin_num_i;
    logic                start_i;
    logic                done_o;
    logic                sat_o;
    logic                unsat_o;
    logic [NUM_VARS-1:0] model_o;

    logic [CLAUSE_W-1:0] clause_tab [NUM_CASES][NUM_CLAUSES];
    logic [BIN_W-1:0]    bin_tab [NUM_CASES];
    logic                exp_sat_tab [NUM_CASES];

    sat_engine_top uut (
        .clk(clk), .rst(rst), .load_we_i(load_we_i), .load_addr_i(load_addr_i),
        .load_clause_i(load_clause_i), .cur_bin_num_i(cur_bin_num_i), .start_i(start_i),
        .done_o(done_o), .sat_o(sat_o), .unsat_o(unsat_o), .model_o(model_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [LIT_W-1:0] lit(int v, bit neg);
        return {1'b1, neg, VAR_W'(v)};
    endfunction

    function automatic logic [LIT_W-1:0] random_lit(int span);
        return lit(int'($urandom % span), bit'($urandom % 2));
    endfunction

    // A clause without any valid literal does not constrain the bin
    function automatic bit clause_holds(logic [CLAUSE_W-1:0] c, logic [NUM_VARS-1:0] a);
        logic [LIT_W-1:0] l;
        bit               any_vld;
        bit               hit;
        any_vld = 1'b0;
        hit     = 1'b0;
        for (int i = 0; i < NUM_LITS; i++)
        begin
            l = c[i*LIT_W +: LIT_W];
            if (l[LIT_VLD])
            begin
                any_vld = 1'b1;
                if (a[l[VAR_W-1:0]] != l[LIT_NEG])
                    hit = 1'b1;
            end
        end
        return !any_vld || hit;
    endfunction

    function automatic bit has_model(int k);
        bit ok;
        for (int m = 0; m < 2**NUM_VARS; m++)
        begin
            ok = 1'b1;
            for (int j = 0; j < NUM_CLAUSES; j++)
                ok = ok & clause_holds(clause_tab[k][j], NUM_VARS'(m));
            if (ok)
                return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic stop_on_error(string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        assert (got === exp)
        else
            stop_on_error($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic build_table();
        int n;
        int span;
        for (int k = 0; k < NUM_CASES; k++)
        begin
            for (int j = 0; j < NUM_CLAUSES; j++)
                clause_tab[k][j] = '0;
            bin_tab[k] = BIN_W'(k + 3);
        end
        clause_tab[0][0] = {10'b0, lit(0, 1'b0)};   // Unit clauses x0 and not x1
        clause_tab[0][1] = {10'b0, lit(1, 1'b1)};
        exp_sat_tab[0]   = 1'b1;
        clause_tab[1][0] = {10'b0, lit(0, 1'b0)};   // Contradiction at the root
        clause_tab[1][1] = {10'b0, lit(0, 1'b1)};
        exp_sat_tab[1]   = 1'b0;
        // The first decision x0=0 fails only after x1 has been flipped too
        for (int j = 0; j < 4; j++)
            clause_tab[2][j] = {lit(2, j[0]), lit(1, j[1]), lit(0, 1'b0)};
        exp_sat_tab[2] = 1'b1;
        for (int j = 0; j < 4; j++)
            clause_tab[3][j] = {5'b0, lit(1, j[1]), lit(0, j[0])};
        exp_sat_tab[3] = 1'b0;
        for (int k = NUM_DIRECTED; k < NUM_CASES; k++)
        begin
            span = (k % 2 == 1) ? 3 : NUM_VARS;   // Few variables make unsat bins likely
            n    = 8 + int'($urandom % 9);
            for (int j = 0; j < n; j++)
                clause_tab[k][j] = {random_lit(span), random_lit(span), random_lit(span)};
            bin_tab[k]     = BIN_W'($urandom % 1000);
            exp_sat_tab[k] = has_model(k);
        end
    endtask

    task automatic run_case(int k);
        int cycles;
        for (int j = 0; j < NUM_CLAUSES; j++)
        begin
            @(negedge clk);
            load_we_i     = 1'b1;
            load_addr_i   = CLS_W'(j);
            load_clause_i = clause_tab[k][j];
        end
        @(negedge clk);
        load_we_i     = 1'b0;
        cur_bin_num_i = bin_tab[k];
        start_i       = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
        check_bit("done_o", done_o, 1'b0);   // Previous result is gone
        check_bit("sat_o", sat_o, 1'b0);
        check_bit("unsat_o", unsat_o, 1'b0);
        cycles = 0;
        while (!done_o && cycles < TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        assert (done_o)
        else
            stop_on_error($sformatf("Case %0d did not finish within %0d cycles", k, TIMEOUT));
        check_bit("sat_o", sat_o, exp_sat_tab[k]);
        check_bit("unsat_o", unsat_o, !exp_sat_tab[k]);
        if (exp_sat_tab[k])
        begin
            for (int j = 0; j < NUM_CLAUSES; j++)
                assert (clause_holds(clause_tab[k][j], model_o))
                else
                    stop_on_error($sformatf("Model %h breaks clause %0d of case %0d",
                                            model_o, j, k));
        end
    endtask

    initial
    begin
        void'($urandom(16364));
        rst           = 1'b0;
        load_we_i     = 1'b0;
        load_addr_i   = '0;
        load_clause_i = '0;
        cur_bin_num_i = '0;
        start_i       = 1'b0;
        build_table();
        repeat (16) @(negedge clk);
        rst = 1'b1;
        for (int k = 0; k < NUM_CASES; k++)
            run_case(k);
        if (uut.u_ctrl.u_props.fail_cnt == 0)
        begin
            $display("test passed");
            $finish;
        end
        else
            stop_on_error("A bound assertion on the control FSM failed");
    end

endmodule

// File: sources.f
rtl/sat_pkg.sv
rtl/ctrl_core.sv
rtl/var_table.sv
rtl/imply_unit.sv
rtl/decide_unit.sv
rtl/analyze_unit.sv
rtl/bkt_unit.sv
rtl/sat_engine_top.sv
verif/ctrl_core_props.sv
verif/sat_engine_tb.sv

// File: Makefile
TOP = sat_engine_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps -f sources.f --top-module $(TOP)

run: compile
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
